// File: project.f
+incdir+test
src/sifhPkg.sv
src/laneIf.sv
src/sampleRouter.sv
src/pixelHistogram.sv
src/resultCollector.sv
src/sifhTop.sv
test/sifhTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the peak finder testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module sifhTb -f project.f

./obj_dir/VsifhTb | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation clean"

// File: src/laneIf.sv
// router to lane link with src and dst modports
`timescale 1ns/1ps

interface laneIf
    import sifhPkg::*;
();
    // sample strobe for this lane only
    logic sampleValid;
    logic [TIME_W-1:0] sample;
    // pass of the sample, also valid on passEnd cycles
    passType pass;
    // last sample of a pass, seen by every lane at once
    logic passEnd;

    // router side
    modport src (output sampleValid, output sample, output pass, output passEnd);

    // histogram lane side
    modport dst (input sampleValid, input sample, input pass, input passEnd);

endinterface

// File: src/pixelHistogram.sv
// single pixel histogram lane: bin memory with lazy clear, running peak,
// fine window start and per-frame result
`timescale 1ns/1ps

module pixelHistogram
    import sifhPkg::*;
(
    input  logic clk,
    input  logic combin_res,
    laneIf.dst lane,
    output logic [TIME_W-1:0] result,
    output logic resultValid
);

    // bin counts, stale unless the matching valid bit is set
    logic [COUNT_W-1:0] binMem [BIN_NUM];
    logic [BIN_NUM-1:0] binValid;

    // running peak of the current pass
    logic [COUNT_W-1:0] maxCount;
    logic [BIN_W-1:0] peakBin;
    // fine window start, follows the coarse peak
    logic [TIME_W-1:0] winLo;

    // stage 1 signals
    logic [TIME_W-1:0] offset;
    logic [BIN_W-1:0] binIdx;
    logic inWindow;
    logic s1Valid;
    logic [BIN_W-1:0] s1Bin;
    logic s1End;
    passType s1Pass;

    // stage 2 signals
    logic clearNow;
    logic [COUNT_W-1:0] newCount;
    logic [COUNT_W-1:0] curMax;
    logic newPeak;
    logic s2End;
    passType s2Pass;

    // window start from a coarse bin, clamped to the time range
    function automatic logic [TIME_W-1:0] windowStart(input logic [BIN_W-1:0] bin);
        logic [TIME_W-1:0] binStart;
        binStart = {bin, {(TIME_W-BIN_W){1'b0}}};
        if (binStart < TIME_W'(HALF_BIN)) begin
            return '0;
        end else if (binStart - TIME_W'(HALF_BIN) > TIME_W'(WINDOW_MAX_LO)) begin
            return TIME_W'(WINDOW_MAX_LO);
        end
        return binStart - TIME_W'(HALF_BIN);
    endfunction

    //****************************************
    // stage 1, bin select
    //****************************************
    always_comb begin
        offset = lane.sample - winLo;
        if (lane.pass == PASS_COARSE) begin
            // upper bits give the coarse bin
            binIdx = lane.sample[TIME_W-1 -: BIN_W];
            inWindow = 1'b1;
        end else begin
            // 2-unit bins inside the window
            binIdx = offset[BIN_W:1];
            inWindow = (lane.sample >= winLo) && (offset < TIME_W'(WINDOW_SPAN));
        end
    end

    //****************************************
    // stage 2, count and peak
    //****************************************
    always_comb begin
        // finalize on this edge drops everything of the old pass
        clearNow = s2End;
        if (binValid[s1Bin] && !clearNow) begin
            newCount = binMem[s1Bin] + 1'b1;
        end else begin
            newCount = COUNT_W'(1);
        end
        curMax = clearNow ? '0 : maxCount;
        // strict compare keeps the earliest bin on ties
        newPeak = s1Valid && (newCount > curMax);
    end

    // control state
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            s1Valid <= 1'b0;
            s1End <= 1'b0;
            s1Pass <= PASS_COARSE;
            s2End <= 1'b0;
            s2Pass <= PASS_COARSE;
            binValid <= '0;
            maxCount <= '0;
            peakBin <= '0;
            winLo <= '0;
            resultValid <= 1'b0;
        end else begin
            // out-of-window samples die here
            s1Valid <= lane.sampleValid && inWindow;
            s1End <= lane.passEnd;
            s1Pass <= lane.pass;
            s2End <= s1End;
            s2Pass <= s1Pass;
            resultValid <= s2End && (s2Pass == PASS_FINE);
            // end of either pass, lazy clear
            if (s2End) begin
                binValid <= '0;
                maxCount <= '0;
                peakBin <= '0;
            end
            // a sample landing on the clear edge still counts
            if (s1Valid) begin
                binValid[s1Bin] <= 1'b1;
            end
            if (newPeak) begin
                maxCount <= newCount;
                peakBin <= s1Bin;
                // window tracks the coarse peak as it moves
                if (s1Pass == PASS_COARSE) begin
                    winLo <= windowStart(s1Bin);
                end
            end
        end
    end

    // memory and payload
    always_ff @(posedge clk) begin
        s1Bin <= binIdx;
        if (s1Valid) begin
            binMem[s1Bin] <= newCount;
        end
        // fine peak back to time units
        if (s2End && (s2Pass == PASS_FINE)) begin
            result <= winLo + {peakBin, 1'b0};
        end
    end

endmodule

// File: src/resultCollector.sv
// result store, done flag and AXI4-Lite read-only slave
`timescale 1ns/1ps

module resultCollector
    import sifhPkg::*;
(
    input  logic clk,
    input  logic combin_res,
    input  logic [TIME_W-1:0] results [PIXEL_NUM],
    input  logic [PIXEL_NUM-1:0] resultValid,
    input  logic frameStart,
    input  logic arvalid,
    output logic arready,
    input  logic [ADDR_W-1:0] araddr,
    output logic rvalid,
    input  logic rready,
    output logic [31:0] rdata,
    output logic [1:0] rresp
);

    // last results, kept across frames
    logic [TIME_W-1:0] resultReg [PIXEL_NUM];
    logic done;

    // read decode
    logic [ADDR_W-1:0] offset;
    logic [31:0] rdNext;
    respType respNext;
    respType respReg;

    //****************************************
    // result capture
    //****************************************
    always_ff @(posedge clk) begin
        for (int i = 0; i < PIXEL_NUM; i++) begin
            if (resultValid[i]) begin
                resultReg[i] <= results[i];
            end
        end
    end

    // all lanes pulse together, set wins over a new frame
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            done <= 1'b0;
        end else if (&resultValid) begin
            done <= 1'b1;
        end else if (frameStart) begin
            done <= 1'b0;
        end
    end

    //****************************************
    // AXI4-Lite read channel
    //****************************************
    always_comb begin
        offset = araddr - ADDR_W'(RESULT_BASE);
        rdNext = '0;
        respNext = RESP_OKAY;
        if (araddr == ADDR_W'(STATUS_ADDR)) begin
            rdNext = {31'b0, done};
        end else if ((araddr >= ADDR_W'(RESULT_BASE)) && (offset < ADDR_W'(4 * PIXEL_NUM))
                     && (offset[1:0] == 2'b00)) begin
            rdNext = {{(32-TIME_W){1'b0}}, resultReg[offset[PIXEL_W+1:2]]};
        end else begin
            // unmapped or unaligned
            respNext = RESP_SLVERR;
        end
    end

    // one read outstanding at a time
    assign arready = !rvalid;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // data and response hold until rready
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= rdNext;
            respReg <= respNext;
        end
    end

    assign rresp = respReg;

endmodule

// File: src/sampleRouter.sv
// sample router with pass tracking and frame counters
`timescale 1ns/1ps

module sampleRouter
    import sifhPkg::*;
(
    input  logic clk,
    input  logic combin_res,
    input  logic wrEn,
    input  logic [TIME_W-1:0] sample,
    laneIf.src lanes [PIXEL_NUM],
    output logic frameStart
);

    //****************************************
    // position of the incoming sample
    //****************************************
    logic [$clog2(SAMPLES_PER_PIXEL)-1:0] sampleCnt;
    logic [PIXEL_W-1:0] pixelCnt;
    logic [$clog2(ACQ_NUM)-1:0] acqCnt;
    passType passState;

    logic lastInPixel;
    logic lastPixel;
    logic lastSample;
    logic firstSample;

    always_comb begin
        lastInPixel = sampleCnt == SAMPLES_PER_PIXEL - 1;
        lastPixel = pixelCnt == PIXEL_NUM - 1;
        lastSample = lastInPixel && lastPixel && (acqCnt == ACQ_NUM - 1);
        // first sample of the coarse pass opens a new frame
        firstSample = (sampleCnt == 0) && (pixelCnt == 0) && (acqCnt == 0)
                      && (passState == PASS_COARSE);
    end

    // counters only move on accepted samples
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
            passState <= PASS_COARSE;
            frameStart <= 1'b0;
        end else begin
            frameStart <= wrEn && firstSample;
            if (wrEn) begin
                sampleCnt <= lastInPixel ? '0 : sampleCnt + 1'b1;
                if (lastInPixel) begin
                    pixelCnt <= lastPixel ? '0 : pixelCnt + 1'b1;
                end
                if (lastInPixel && lastPixel) begin
                    acqCnt <= (acqCnt == ACQ_NUM - 1) ? '0 : acqCnt + 1'b1;
                end
                // swap coarse and fine after the last sample of a pass
                if (lastSample) begin
                    passState <= (passState == PASS_COARSE) ? PASS_FINE : PASS_COARSE;
                end
            end
        end
    end

    //****************************************
    // per-lane output registers
    //****************************************
    for (genvar g = 0; g < PIXEL_NUM; g++) begin : genLane
        always_ff @(posedge clk or negedge combin_res) begin
            if (!combin_res) begin
                lanes[g].sampleValid <= 1'b0;
                lanes[g].sample <= '0;
                lanes[g].pass <= PASS_COARSE;
                lanes[g].passEnd <= 1'b0;
            end else begin
                // only the addressed pixel sees the strobe
                lanes[g].sampleValid <= wrEn && (pixelCnt == PIXEL_W'(g));
                lanes[g].sample <= sample;
                // pass before any toggle on this edge
                lanes[g].pass <= passState;
                // broadcast end of pass
                lanes[g].passEnd <= wrEn && lastSample;
            end
        end
    end

endmodule

// File: src/sifhPkg.sv
// shared sizes, window constants and the pass/response enums
// for the two-pass histogram peak finder
package sifhPkg;

    //****************************************
    // data path sizes
    //****************************************
    // timestamp width from the TDC
    localparam int TIME_W = 12;
    // coarse bin index, upper bits of a timestamp
    localparam int BIN_W = 6;
    localparam int BIN_NUM = 64;
    // per-bin counter, at most 24 hits per pass
    localparam int COUNT_W = 8;

    //****************************************
    // frame layout
    //****************************************
    localparam int PIXEL_NUM = 4;
    localparam int PIXEL_W = 2;
    // consecutive samples of one pixel in one acquisition
    localparam int SAMPLES_PER_PIXEL = 3;
    // acquisitions in each pass
    localparam int ACQ_NUM = 8;

    //****************************************
    // fine window
    //****************************************
    // window opens half a coarse bin below the peak bin
    localparam int HALF_BIN = 32;
    localparam int WINDOW_SPAN = 128;
    // last start that keeps the window inside the time range
    localparam int WINDOW_MAX_LO = 3968;

    //****************************************
    // register map
    //****************************************
    localparam int ADDR_W = 5;
    localparam int STATUS_ADDR = 0;
    // pixel n result sits at RESULT_BASE + 4*n
    localparam int RESULT_BASE = 4;

    typedef enum logic {PASS_COARSE, PASS_FINE} passType;

    typedef enum logic [1:0] {RESP_OKAY = 2'd0, RESP_SLVERR = 2'd2} respType;

endpackage

// File: src/sifhTop.sv
// top level: sample router, histogram lanes and result collector
`timescale 1ns/1ps

module sifhTop
    import sifhPkg::*;
(
    input  logic clk,
    input  logic combin_res,
    // sample stream, no back-pressure
    input  logic wrEn,
    input  logic [TIME_W-1:0] sample,
    // AXI4-Lite read address
    input  logic arvalid,
    output logic arready,
    input  logic [ADDR_W-1:0] araddr,
    // AXI4-Lite read data
    output logic rvalid,
    input  logic rready,
    output logic [31:0] rdata,
    output logic [1:0] rresp
);

    //****************************************
    // internal links
    //****************************************
    laneIf laneBus [PIXEL_NUM] ();

    logic [TIME_W-1:0] laneResult [PIXEL_NUM];
    logic [PIXEL_NUM-1:0] laneResultValid;
    logic frameStart;

    // counters and steering
    sampleRouter uRouter (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .sample     (sample),
        .lanes      (laneBus),
        .frameStart (frameStart)
    );

    // one histogram lane per pixel
    for (genvar g = 0; g < PIXEL_NUM; g++) begin : genPixel
        pixelHistogram uLane (
            .clk         (clk),
            .combin_res  (combin_res),
            .lane        (laneBus[g]),
            .result      (laneResult[g]),
            .resultValid (laneResultValid[g])
        );
    end

    // result registers and bus slave
    resultCollector uCollector (
        .clk         (clk),
        .combin_res  (combin_res),
        .results     (laneResult),
        .resultValid (laneResultValid),
        .frameStart  (frameStart),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp)
    );

endmodule

// File: test/sifhTbModel.svh
// reference model of the two-pass peak search
// plus register address helpers
`ifndef SIFH_TB_MODEL_SVH
`define SIFH_TB_MODEL_SVH

// one pass of one pixel, in arrival order
typedef logic [TIME_W-1:0] passList [SAMPLES_PER_PIXEL*ACQ_NUM];

// window start for a coarse peak bin, clamped to the time range
function automatic int windowFor(input int bin);
    int start;
    start = bin * (1 << (TIME_W - BIN_W)) - HALF_BIN;
    if (start < 0) return 0;
    if (start > WINDOW_MAX_LO) return WINDOW_MAX_LO;
    return start;
endfunction

// expected result of one pixel from its two passes
function automatic int expectResult(input passList coarse, input passList fine);
    int count [BIN_NUM];
    int maxCnt;
    int peak;
    int idx;
    int winStart;
    //****************************************
    // coarse pass on the upper bits
    //****************************************
    foreach (count[b]) count[b] = 0;
    maxCnt = 0;
    peak = 0;
    foreach (coarse[i]) begin
        idx = int'(coarse[i]) >> (TIME_W - BIN_W);
        count[idx]++;
        // strictly greater, first bin at the max keeps it
        if (count[idx] > maxCnt) begin
            maxCnt = count[idx];
            peak = idx;
        end
    end
    winStart = windowFor(peak);
    //****************************************
    // fine pass, 2-unit bins in the window
    //****************************************
    foreach (count[b]) count[b] = 0;
    maxCnt = 0;
    peak = 0;
    foreach (fine[i]) begin
        idx = int'(fine[i]) - winStart;
        // outside the window, dropped
        if (idx >= 0 && idx < WINDOW_SPAN) begin
            count[idx / 2]++;
            if (count[idx / 2] > maxCnt) begin
                maxCnt = count[idx / 2];
                peak = idx / 2;
            end
        end
    end
    return winStart + 2 * peak;
endfunction

// register map
function automatic logic [ADDR_W-1:0] resultAddr(input int pixel);
    return ADDR_W'(RESULT_BASE + 4 * pixel);
endfunction

// first word past the result block
function automatic logic [ADDR_W-1:0] unmappedAddr();
    return ADDR_W'(RESULT_BASE + 4 * PIXEL_NUM);
endfunction

`endif

// File: test/sifhTb.sv
// testbench: clock and reset, frame stimulus, AXI4-Lite reads
// and comparison against the reference model
`timescale 1ns/1ps

module sifhTb
    import sifhPkg::*;
();

    localparam int PASS_LEN = SAMPLES_PER_PIXEL * ACQ_NUM;
    // idle cycles between coarse and fine pass
    localparam int PASS_GAP = 3;
    // last sample to done, pipeline latency
    localparam int PIPE_DRAIN = 6;
    localparam int WAIT_LIMIT = 100;

    logic clk;
    logic combin_res;
    logic wrEn;
    logic [TIME_W-1:0] sample;
    logic arvalid;
    logic arready;
    logic [ADDR_W-1:0] araddr;
    logic rvalid;
    logic rready;
    logic [31:0] rdata;
    logic [1:0] rresp;

    int errorCount;
    int checkCount;

    `include "sifhTbModel.svh"

    // current frame and its expected results
    passList coarseSmp [PIXEL_NUM];
    passList fineSmp [PIXEL_NUM];
    int expResult [PIXEL_NUM];

    sifhTop UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //****************************************
    // checking and run end
    //****************************************
    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic finishRun();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    task automatic timeoutAbort(input string what);
        errorCount++;
        $display("timeout while waiting for %s", what);
        finishRun();
    endtask

    //****************************************
    // AXI4-Lite read
    //****************************************
    // holdCycles keeps rready low with the response pending
    task automatic axiRead(input logic [ADDR_W-1:0] addr, input int holdCycles,
                           output logic [31:0] data, output logic [1:0] resp);
        int n;
        @(posedge clk);
        arvalid <= 1'b1;
        araddr <= addr;
        n = 0;
        do begin
            @(negedge clk);
            if (n == WAIT_LIMIT) timeoutAbort("arready");
            n++;
        end while (!arready);
        // handshake on this edge
        @(posedge clk);
        arvalid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            if (n == WAIT_LIMIT) timeoutAbort("rvalid");
            n++;
        end while (!rvalid);
        data = rdata;
        resp = rresp;
        // a second request waits behind the pending response
        if (holdCycles > 0) begin
            @(posedge clk);
            arvalid <= 1'b1;
            araddr <= ADDR_W'(STATUS_ADDR);
        end
        // response must not move under back-pressure
        repeat (holdCycles) begin
            @(negedge clk);
            checkValue("rvalid", 32'(rvalid), 32'd1);
            checkValue("rdata", rdata, data);
            checkValue("rresp", 32'(rresp), 32'(resp));
            checkValue("arready", 32'(arready), 32'd0);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // poll STATUS until the done bit
    task automatic waitDone();
        logic [31:0] data;
        logic [1:0] resp;
        int n;
        n = 0;
        do begin
            if (n == WAIT_LIMIT) timeoutAbort("done flag");
            n++;
            axiRead(ADDR_W'(STATUS_ADDR), 0, data, resp);
        end while (data[0] !== 1'b1);
        checkValue("rresp", 32'(resp), 32'(RESP_OKAY));
    endtask

    task automatic checkResults();
        logic [31:0] data;
        logic [1:0] resp;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            axiRead(resultAddr(p), 0, data, resp);
            checkValue($sformatf("result%0d", p), data, 32'(expResult[p]));
            checkValue("rresp", 32'(resp), 32'(RESP_OKAY));
        end
    endtask

    //****************************************
    // stimulus
    //****************************************
    // acquisition, then pixel, then sample within pixel
    task automatic sendPass(input bit fine);
        for (int a = 0; a < ACQ_NUM; a++) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                for (int k = 0; k < SAMPLES_PER_PIXEL; k++) begin
                    @(posedge clk);
                    wrEn <= 1'b1;
                    sample <= fine ? fineSmp[p][a * SAMPLES_PER_PIXEL + k]
                                   : coarseSmp[p][a * SAMPLES_PER_PIXEL + k];
                end
            end
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            wrEn <= 1'b0;
        end
    endtask

    // leaves wrEn high so a next frame can follow directly
    task automatic sendFrame();
        sendPass(1'b0);
        idleCycles(PASS_GAP);
        sendPass(1'b1);
    endtask

    function automatic logic [TIME_W-1:0] clampTime(input int v);
        if (v < 0) return '0;
        if (v >= (1 << TIME_W)) return '1;
        return TIME_W'(v);
    endfunction

    // hits around a center, fine noise over the full range
    task automatic genCluster(input int p, input int center, input int spread,
                              input int noisePct);
        for (int i = 0; i < PASS_LEN; i++) begin
            coarseSmp[p][i] = clampTime(center + int'($urandom_range(2 * spread)) - spread);
            if (int'($urandom_range(99)) < noisePct) begin
                fineSmp[p][i] = TIME_W'($urandom_range(4095));
            end else begin
                fineSmp[p][i] = clampTime(center + int'($urandom_range(spread)) - spread / 2);
            end
        end
    endtask

    task automatic computeExpected();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            expResult[p] = expectResult(coarseSmp[p], fineSmp[p]);
        end
    endtask

    //****************************************
    // test sequence
    //****************************************
    initial begin
        logic [31:0] data;
        logic [1:0] resp;
        errorCount = 0;
        checkCount = 0;
        void'($urandom(32'hbd30b80a));
        combin_res = 1'b0;
        wrEn = 1'b0;
        sample = '0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        repeat (3) @(posedge clk);
        combin_res <= 1'b1;

        // idle bus after reset
        @(negedge clk);
        checkValue("arready", 32'(arready), 32'd1);
        axiRead(ADDR_W'(STATUS_ADDR), 0, data, resp);
        checkValue("status", data, 32'd0);
        checkValue("rresp", 32'(resp), 32'(RESP_OKAY));

        // frame A, random clusters and both clamp ends
        genCluster(0, int'($urandom_range(3700, 300)), 40, 20);
        genCluster(1, int'($urandom_range(3700, 300)), 40, 20);
        genCluster(2, 12, 12, 0);
        genCluster(3, 4085, 10, 0);
        // fine hits below 4000 count only with the window clamped to 3968
        for (int i = 0; i < PASS_LEN; i++) begin
            fineSmp[3][i] = TIME_W'(3970 + int'($urandom_range(20)));
        end
        computeExpected();
        sendFrame();
        idleCycles(1);
        waitDone();
        checkResults();

        // frame B, ties and noise
        genCluster(1, int'($urandom_range(3700, 300)), 30, 50);
        genCluster(2, 2000, 30, 0);
        for (int i = 0; i < PASS_LEN; i++) begin
            // bin 20 reaches each count before bin 10
            coarseSmp[0][i] = (i % 2 == 0) ? TIME_W'(1285) : TIME_W'(649);
            // noise at 3000 outnumbers both in-window bins
            fineSmp[0][i] = (i % 2 == 0) ? TIME_W'(3000)
                          : ((i % 4 == 1) ? TIME_W'(1288) : TIME_W'(1258));
            // nothing near the coarse peak
            fineSmp[2][i] = TIME_W'($urandom_range(1500));
            // bin 40 fills first, bin 41 only ties
            coarseSmp[3][i] = (i < PASS_LEN / 2) ? TIME_W'(2570) : TIME_W'(2630);
            fineSmp[3][i] = TIME_W'(2540 + 55 * (i % 3));
        end
        computeExpected();
        fork
            sendFrame();
            begin
                // done of frame A cleared by the first sample
                repeat (20) @(posedge clk);
                axiRead(ADDR_W'(STATUS_ADDR), 0, data, resp);
                checkValue("status", data, 32'd0);
            end
        join

        // frame C straight behind B, B read back meanwhile
        for (int p = 0; p < PIXEL_NUM; p++) begin
            genCluster(p, int'($urandom_range(3900, 100)), 50, 10);
        end
        fork
            sendFrame();
            begin
                waitDone();
                checkResults();
            end
        join
        idleCycles(PIPE_DRAIN);
        computeExpected();
        waitDone();
        checkResults();

        // unmapped read held under back-pressure
        axiRead(unmappedAddr(), 5, data, resp);
        checkValue("rdata", data, 32'd0);
        checkValue("rresp", 32'(resp), 32'(RESP_SLVERR));

        finishRun();
    end

endmodule
